//--- logic/frv_core_pkg.sv
// --------------------
// Architectural widths and RV32 encodings of the supported integer subset
// --------------------
`default_nettype none

package frv_core_pkg;

    localparam int XLEN = 32;                           // Data path width

    typedef logic [XLEN-1:0] xlen_t;                    // Data word
    typedef logic [31:0]     instr_t;                   // Instruction word
    typedef logic [4:0]      reg_addr_t;                // Register index

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;     // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;     // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;         // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;         // LW and SW width

    // funct7 codes
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;     // SUB variant

endpackage

`default_nettype wire

//--- logic/frv_gprs.sv
// --------------------
// General purpose registers, two combinational reads and one write, x0 reads zero
// --------------------
`default_nettype none

module frv_gprs #(
    parameter int NUM_REGS = 32                         // 16 for RV32E
) (
    input  logic                    g_clk,
    input  logic                    arst_n,
    input  frv_core_pkg::reg_addr_t rs1_addr,
    input  frv_core_pkg::reg_addr_t rs2_addr,
    output frv_core_pkg::xlen_t     rs1_data,
    output frv_core_pkg::xlen_t     rs2_data,
    input  logic                    rd_wen,
    input  frv_core_pkg::reg_addr_t rd_addr,
    input  frv_core_pkg::xlen_t     rd_wdata
);

    frv_core_pkg::xlen_t regs [1:NUM_REGS-1];           // No storage for x0

    // No write bypass, decode forwards from writeback
    assign rs1_data = (rs1_addr != '0 && rs1_addr < NUM_REGS) ? regs[rs1_addr] : '0;
    assign rs2_data = (rs2_addr != '0 && rs2_addr < NUM_REGS) ? regs[rs2_addr] : '0;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= {frv_core_pkg::XLEN{1'b0}};
            end
        end else if (rd_wen && rd_addr != '0 && rd_addr < NUM_REGS) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/frv_pipe_pkg.sv
// --------------------
// Micro-op and functional unit codes passed down the pipeline stages
// --------------------
`default_nettype none

package frv_pipe_pkg;

    // ALU operation, also the address add for loads and stores
    typedef enum logic [2:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLT,                                        // Signed compare
        UOP_PASS_B                                      // LUI result
    } uop_e;

    // Unit that finishes the instruction
    typedef enum logic [1:0] {
        FU_NONE,                                        // Unsupported, retires as no-op
        FU_ALU,
        FU_LOAD,
        FU_STORE
    } fu_e;

endpackage

`default_nettype wire

//--- logic/frv_pipeline.sv
// --------------------
// RV32 integer data pipeline with decode, execute, memory and writeback
// Runs ADD SUB AND OR XOR SLT ADDI LUI LW SW; other words retire as no-ops
// --------------------
`default_nettype none

module frv_pipeline #(
    parameter int NUM_REGS = 32                         // Architectural registers
) (
    input  logic                    g_clk,              // Global clock
    input  logic                    arst_n,             // Async reset, active low
    input  logic                    instr_valid,        // Instruction offered
    output logic                    instr_ready,        // Decode takes it
    input  frv_core_pkg::instr_t    instr_data,
    output logic                    dmem_req,           // Held until grant
    output logic                    dmem_wen,           // Store request
    output frv_core_pkg::xlen_t     dmem_addr,
    output frv_core_pkg::xlen_t     dmem_wdata,
    input  logic                    dmem_gnt,           // Request completes
    input  frv_core_pkg::xlen_t     dmem_rdata,         // Load data, with grant
    output logic                    trs_valid,          // One pulse per retire
    output frv_core_pkg::instr_t    trs_instr,
    output frv_core_pkg::reg_addr_t trs_rd,
    output frv_core_pkg::xlen_t     trs_wdata
);

    // Register file
    frv_core_pkg::reg_addr_t rs1_addr;
    frv_core_pkg::reg_addr_t rs2_addr;
    frv_core_pkg::xlen_t     rs1_data;
    frv_core_pkg::xlen_t     rs2_data;
    logic                    rd_wen;
    frv_core_pkg::reg_addr_t rd_addr;
    frv_core_pkg::xlen_t     rd_wdata;

    // Forwarding from the later stages
    frv_core_pkg::reg_addr_t fwd_s2_rd;
    frv_core_pkg::reg_addr_t fwd_s3_rd;
    frv_core_pkg::reg_addr_t fwd_s4_rd;
    frv_core_pkg::xlen_t     fwd_s2_wdata;
    frv_core_pkg::xlen_t     fwd_s3_wdata;
    frv_core_pkg::xlen_t     fwd_s4_wdata;
    logic                    fwd_s2_load;
    logic                    fwd_s3_load;

    // --------------------
    // Stage links
    frv_stage_if s2_if ();                              // Decode to execute
    frv_stage_if s3_if ();                              // Execute to memory
    frv_stage_if s4_if ();                              // Memory to writeback

    frv_pipeline_decode i_pipeline_s1_decode (
        .g_clk, .arst_n,
        .instr_valid, .instr_ready, .instr_data,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .fwd_s2_rd, .fwd_s3_rd, .fwd_s4_rd,
        .fwd_s2_wdata, .fwd_s3_wdata, .fwd_s4_wdata,
        .fwd_s2_load, .fwd_s3_load,
        .s2             (s2_if.producer)
    );

    frv_pipeline_execute i_pipeline_s2_execute (
        .g_clk, .arst_n,
        .s2             (s2_if.consumer),
        .s3             (s3_if.producer),
        .fwd_s2_rd, .fwd_s2_wdata, .fwd_s2_load
    );

    frv_pipeline_memory i_pipeline_s3_memory (
        .g_clk, .arst_n,
        .s3             (s3_if.consumer),
        .s4             (s4_if.producer),
        .dmem_req, .dmem_wen, .dmem_addr, .dmem_wdata, .dmem_gnt, .dmem_rdata,
        .fwd_s3_rd, .fwd_s3_wdata, .fwd_s3_load
    );

    frv_pipeline_writeback i_pipeline_s4_writeback (
        .g_clk, .arst_n,
        .s4             (s4_if.consumer),
        .rd_wen, .rd_addr, .rd_wdata,
        .fwd_s4_rd, .fwd_s4_wdata,
        .trs_valid, .trs_instr, .trs_rd, .trs_wdata
    );

    frv_gprs #(
        .NUM_REGS       (NUM_REGS)
    ) i_gprs (
        .g_clk, .arst_n,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rd_wen, .rd_addr, .rd_wdata
    );

endmodule

`default_nettype wire

//--- logic/frv_pipeline_decode.sv
// --------------------
// Decode stage: buffers the incoming word, reads and forwards operands,
// bubbles on load-use hazards and loads the decode to execute register
// --------------------
`default_nettype none

module frv_pipeline_decode (
    input  logic                    g_clk,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  frv_core_pkg::instr_t    instr_data,
    output frv_core_pkg::reg_addr_t rs1_addr,
    output frv_core_pkg::reg_addr_t rs2_addr,
    input  frv_core_pkg::xlen_t     rs1_data,
    input  frv_core_pkg::xlen_t     rs2_data,
    input  frv_core_pkg::reg_addr_t fwd_s2_rd,          // Execute destination
    input  frv_core_pkg::reg_addr_t fwd_s3_rd,          // Memory destination
    input  frv_core_pkg::reg_addr_t fwd_s4_rd,          // Writeback destination
    input  frv_core_pkg::xlen_t     fwd_s2_wdata,
    input  frv_core_pkg::xlen_t     fwd_s3_wdata,
    input  frv_core_pkg::xlen_t     fwd_s4_wdata,
    input  logic                    fwd_s2_load,        // Result not known yet
    input  logic                    fwd_s3_load,
    frv_stage_if.producer           s2
);

    logic                    active;                    // First cycle after reset done
    logic                    s1_valid;
    frv_core_pkg::instr_t    s1_instr;                  // Instruction buffer
    logic                    s2_free;                   // Execute register can load
    logic                    s1_go;                     // Item leaves decode
    logic                    use_rs1;
    logic                    use_rs2;
    logic [2:0]              hzd1;                      // rs1 hits {wb, mem, exe}
    logic [2:0]              hzd2;
    logic                    bubble;
    frv_core_pkg::xlen_t     rs1_val;                   // Operands after forwarding
    frv_core_pkg::xlen_t     rs2_val;
    frv_core_pkg::xlen_t     imm_i;
    frv_core_pkg::xlen_t     imm_s;
    frv_pipe_pkg::uop_e      d_uop;
    frv_pipe_pkg::fu_e       d_fu;
    frv_core_pkg::xlen_t     d_opr_b;
    frv_core_pkg::reg_addr_t d_rd;

    function automatic logic src_hit(input logic used, input frv_core_pkg::reg_addr_t src,
                                     input frv_core_pkg::reg_addr_t dst);
        return used && (src != '0) && (src == dst);     // x0 never hazards
    endfunction

    // --------------------
    // Hazards and forwarding
    assign rs1_addr = s1_instr[19:15];
    assign rs2_addr = s1_instr[24:20];
    assign use_rs1  = s1_instr[6:0] inside {frv_core_pkg::OPC_OP, frv_core_pkg::OPC_OP_IMM,
                                            frv_core_pkg::OPC_LOAD, frv_core_pkg::OPC_STORE};
    assign use_rs2  = s1_instr[6:0] inside {frv_core_pkg::OPC_OP, frv_core_pkg::OPC_STORE};

    assign hzd1 = {src_hit(use_rs1, rs1_addr, fwd_s4_rd), src_hit(use_rs1, rs1_addr, fwd_s3_rd),
                   src_hit(use_rs1, rs1_addr, fwd_s2_rd)};
    assign hzd2 = {src_hit(use_rs2, rs2_addr, fwd_s4_rd), src_hit(use_rs2, rs2_addr, fwd_s3_rd),
                   src_hit(use_rs2, rs2_addr, fwd_s2_rd)};

    // Youngest match wins
    assign rs1_val = hzd1[0] ? fwd_s2_wdata : hzd1[1] ? fwd_s3_wdata :
                     hzd1[2] ? fwd_s4_wdata : rs1_data;
    assign rs2_val = hzd2[0] ? fwd_s2_wdata : hzd2[1] ? fwd_s3_wdata :
                     hzd2[2] ? fwd_s4_wdata : rs2_data;

    // Wait for loads to reach writeback
    assign bubble = ((hzd1[0] || hzd2[0]) && fwd_s2_load) ||
                    ((hzd1[1] || hzd2[1]) && fwd_s3_load);

    assign s2_free     = !s2.valid || s2.ready;
    assign s1_go       = s1_valid && !bubble && s2_free;
    assign instr_ready = active && (!s1_valid || s1_go);

    // --------------------
    // Instruction decode
    assign imm_i = {{20{s1_instr[31]}}, s1_instr[31:20]};
    assign imm_s = {{20{s1_instr[31]}}, s1_instr[31:25], s1_instr[11:7]};

    always_comb begin
        d_uop   = frv_pipe_pkg::UOP_ADD;                // Also the address add
        d_fu    = frv_pipe_pkg::FU_NONE;
        d_opr_b = rs2_val;
        case (s1_instr[6:0])
            frv_core_pkg::OPC_OP: begin
                d_fu = frv_pipe_pkg::FU_ALU;
                case ({s1_instr[31:25], s1_instr[14:12]})
                    {frv_core_pkg::F7_BASE, frv_core_pkg::F3_ADD_SUB}: d_uop = frv_pipe_pkg::UOP_ADD;
                    {frv_core_pkg::F7_SUB,  frv_core_pkg::F3_ADD_SUB}: d_uop = frv_pipe_pkg::UOP_SUB;
                    {frv_core_pkg::F7_BASE, frv_core_pkg::F3_SLT}:     d_uop = frv_pipe_pkg::UOP_SLT;
                    {frv_core_pkg::F7_BASE, frv_core_pkg::F3_XOR}:     d_uop = frv_pipe_pkg::UOP_XOR;
                    {frv_core_pkg::F7_BASE, frv_core_pkg::F3_OR}:      d_uop = frv_pipe_pkg::UOP_OR;
                    {frv_core_pkg::F7_BASE, frv_core_pkg::F3_AND}:     d_uop = frv_pipe_pkg::UOP_AND;
                    default: d_fu = frv_pipe_pkg::FU_NONE;  // Shifts, SLTU
                endcase
            end
            frv_core_pkg::OPC_OP_IMM: if (s1_instr[14:12] == frv_core_pkg::F3_ADD_SUB) begin
                d_fu    = frv_pipe_pkg::FU_ALU;         // ADDI only
                d_opr_b = imm_i;
            end
            frv_core_pkg::OPC_LUI: begin
                d_fu    = frv_pipe_pkg::FU_ALU;
                d_uop   = frv_pipe_pkg::UOP_PASS_B;
                d_opr_b = {s1_instr[31:12], 12'h000};
            end
            frv_core_pkg::OPC_LOAD: if (s1_instr[14:12] == frv_core_pkg::F3_WORD) begin
                d_fu    = frv_pipe_pkg::FU_LOAD;
                d_opr_b = imm_i;
            end
            frv_core_pkg::OPC_STORE: if (s1_instr[14:12] == frv_core_pkg::F3_WORD) begin
                d_fu    = frv_pipe_pkg::FU_STORE;
                d_opr_b = imm_s;
            end
            default: d_fu = frv_pipe_pkg::FU_NONE;
        endcase
    end

    // Stores and unsupported words write nothing
    assign d_rd = (d_fu == frv_pipe_pkg::FU_ALU || d_fu == frv_pipe_pkg::FU_LOAD) ?
                  s1_instr[11:7] : '0;

    // --------------------
    // Buffer and decode to execute register
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            s1_valid <= 1'b0;
            s2.valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (instr_ready) begin
                s1_valid <= instr_valid;                // Refill or drain
            end
            if (s2_free) begin
                s2.valid <= s1_valid && !bubble;        // Bubble enters as empty slot
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (instr_valid && instr_ready) begin
            s1_instr <= instr_data;
        end
        if (s1_go) begin
            s2.rd         <= d_rd;
            s2.opr_a      <= rs1_val;
            s2.opr_b      <= d_opr_b;
            s2.store_data <= rs2_val;
            s2.uop        <= d_uop;
            s2.fu         <= d_fu;
            s2.instr      <= s1_instr;
        end
    end

endmodule

`default_nettype wire

//--- logic/frv_pipeline_execute.sv
// --------------------
// Execute stage: ALU and load/store address add into the execute to memory register
// --------------------
`default_nettype none

module frv_pipeline_execute (
    input  logic                    g_clk,
    input  logic                    arst_n,
    frv_stage_if.consumer           s2,
    frv_stage_if.producer           s3,
    output frv_core_pkg::reg_addr_t fwd_s2_rd,          // Zero when empty
    output frv_core_pkg::xlen_t     fwd_s2_wdata,
    output logic                    fwd_s2_load         // Value still to come
);

    frv_core_pkg::xlen_t alu_result;

    always_comb begin
        case (s2.uop)
            frv_pipe_pkg::UOP_ADD: alu_result = s2.opr_a + s2.opr_b;
            frv_pipe_pkg::UOP_SUB: alu_result = s2.opr_a - s2.opr_b;    // Wraps
            frv_pipe_pkg::UOP_AND: alu_result = s2.opr_a & s2.opr_b;
            frv_pipe_pkg::UOP_OR:  alu_result = s2.opr_a | s2.opr_b;
            frv_pipe_pkg::UOP_XOR: alu_result = s2.opr_a ^ s2.opr_b;
            frv_pipe_pkg::UOP_SLT: alu_result = {{(frv_core_pkg::XLEN-1){1'b0}},
                                                 $signed(s2.opr_a) < $signed(s2.opr_b)};
            default:               alu_result = s2.opr_b;               // LUI
        endcase
    end

    assign s2.ready = !s3.valid || s3.ready;

    assign fwd_s2_rd    = s2.valid ? s2.rd : '0;
    assign fwd_s2_wdata = alu_result;
    assign fwd_s2_load  = s2.valid && (s2.fu == frv_pipe_pkg::FU_LOAD);

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s3.valid <= 1'b0;
        end else if (s2.ready) begin
            s3.valid <= s2.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s2.valid && s2.ready) begin
            s3.rd         <= s2.rd;
            s3.opr_a      <= alu_result;                // Result or address
            s3.opr_b      <= s2.opr_b;
            s3.store_data <= s2.store_data;
            s3.uop        <= s2.uop;
            s3.fu         <= s2.fu;
            s3.instr      <= s2.instr;
        end
    end

endmodule

`default_nettype wire

//--- logic/frv_pipeline_memory.sv
// --------------------
// Memory stage: word requests on the req/gnt data port, held until granted
// --------------------
`default_nettype none

module frv_pipeline_memory (
    input  logic                    g_clk,
    input  logic                    arst_n,
    frv_stage_if.consumer           s3,
    frv_stage_if.producer           s4,
    output logic                    dmem_req,
    output logic                    dmem_wen,
    output frv_core_pkg::xlen_t     dmem_addr,
    output frv_core_pkg::xlen_t     dmem_wdata,
    input  logic                    dmem_gnt,
    input  frv_core_pkg::xlen_t     dmem_rdata,
    output frv_core_pkg::reg_addr_t fwd_s3_rd,
    output frv_core_pkg::xlen_t     fwd_s3_wdata,
    output logic                    fwd_s3_load
);

    logic is_load;
    logic is_store;
    logic s4_free;                                      // Writeback register can load
    logic s3_move;                                      // Item leaves memory

    assign is_load  = s3.valid && (s3.fu == frv_pipe_pkg::FU_LOAD);
    assign is_store = s3.valid && (s3.fu == frv_pipe_pkg::FU_STORE);
    assign s4_free  = !s4.valid || s4.ready;

    // Request stays up and stable until granted
    assign dmem_req   = (is_load || is_store) && s4_free;
    assign dmem_wen   = is_store;
    assign dmem_addr  = s3.opr_a;
    assign dmem_wdata = s3.store_data;

    assign s3_move  = s3.valid && s4_free && (!(is_load || is_store) || dmem_gnt);
    assign s3.ready = !s3.valid || s3_move;

    assign fwd_s3_rd    = s3.valid ? s3.rd : '0;
    assign fwd_s3_wdata = s3.opr_a;
    assign fwd_s3_load  = is_load;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s4.valid <= 1'b0;
        end else if (s4_free) begin
            s4.valid <= s3_move;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_move) begin
            s4.rd         <= s3.rd;
            s4.opr_a      <= s3.opr_a;
            s4.opr_b      <= is_load ? dmem_rdata : s3.opr_b;   // Load data rides in B
            s4.store_data <= s3.store_data;
            s4.uop        <= s3.uop;
            s4.fu         <= s3.fu;
            s4.instr      <= s3.instr;
        end
    end

endmodule

`default_nettype wire

//--- logic/frv_pipeline_writeback.sv
// --------------------
// Writeback stage: register file write and the registered retire trace
// --------------------
`default_nettype none

module frv_pipeline_writeback (
    input  logic                    g_clk,
    input  logic                    arst_n,
    frv_stage_if.consumer           s4,
    output logic                    rd_wen,
    output frv_core_pkg::reg_addr_t rd_addr,
    output frv_core_pkg::xlen_t     rd_wdata,
    output frv_core_pkg::reg_addr_t fwd_s4_rd,
    output frv_core_pkg::xlen_t     fwd_s4_wdata,       // Final, never a pending load
    output logic                    trs_valid,
    output frv_core_pkg::instr_t    trs_instr,
    output frv_core_pkg::reg_addr_t trs_rd,
    output frv_core_pkg::xlen_t     trs_wdata
);

    frv_core_pkg::xlen_t wb_data;

    assign s4.ready = 1'b1;                             // Retires every cycle
    assign wb_data  = (s4.fu == frv_pipe_pkg::FU_LOAD) ? s4.opr_b : s4.opr_a;

    assign rd_wen   = s4.valid && (s4.rd != '0);
    assign rd_addr  = s4.rd;
    assign rd_wdata = wb_data;

    assign fwd_s4_rd    = s4.valid ? s4.rd : '0;
    assign fwd_s4_wdata = wb_data;

    // --------------------
    // Retire trace
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            trs_valid <= 1'b0;
        end else begin
            trs_valid <= s4.valid;                      // One pulse per item
        end
    end

    always_ff @(posedge g_clk) begin
        if (s4.valid) begin
            trs_instr <= s4.instr;
            trs_rd    <= s4.rd;
            trs_wdata <= rd_wen ? wb_data : '0;         // Zero when nothing written
        end
    end

endmodule

`default_nettype wire

//--- logic/frv_stage_if.sv
// --------------------
// One instruction moving between two pipeline stages, valid/ready handshake
// --------------------
`default_nettype none

interface frv_stage_if;

    logic                    valid;                     // Item present
    logic                    ready;                     // Consumer takes it this cycle
    frv_core_pkg::reg_addr_t rd;                        // Destination, zero if none
    frv_core_pkg::xlen_t     opr_a;                     // Operand A, later the result
    frv_core_pkg::xlen_t     opr_b;                     // Operand B, later load data
    frv_core_pkg::xlen_t     store_data;                // SW data
    frv_pipe_pkg::uop_e      uop;
    frv_pipe_pkg::fu_e       fu;
    frv_core_pkg::instr_t    instr;                     // Word for the retire trace

    modport producer (
        output valid, rd, opr_a, opr_b, store_data, uop, fu, instr,
        input  ready
    );

    modport consumer (
        input  valid, rd, opr_a, opr_b, store_data, uop, fu, instr,
        output ready
    );

endinterface

`default_nettype wire

//--- sources.f
logic/frv_core_pkg.sv
logic/frv_pipe_pkg.sv
logic/frv_stage_if.sv
logic/frv_pipeline_decode.sv
logic/frv_pipeline_execute.sv
logic/frv_pipeline_memory.sv
logic/frv_pipeline_writeback.sv
logic/frv_gprs.sv
logic/frv_pipeline.sv
tb/tb_frv_pipeline.sv

//--- tb/frv_patterns.txt
# M addr value = initial memory word, I word = instruction in input order
# R instr rd wdata = expected retire record, S addr data = expected store
M 00000100 12345678
M 00000108 0badc0de
I 10000093  # addi x1, x0, 256
I 0000a103  # lw   x2, 0(x1)
I 001101b3  # add  x3, x2, x1   load-use
I 80000237  # lui  x4, 0x80000
I 003222b3  # slt  x5, x4, x3
I 40308333  # sub  x6, x1, x3
I 002343b3  # xor  x7, x6, x2
I 0070a423  # sw   x7, 8(x1)
I 0080a403  # lw   x8, 8(x1)    reads the stored word
I 003474b3  # and  x9, x8, x3
I 0054e533  # or   x10, x9, x5
I 0100a583  # lw   x11, 16(x1)  unwritten address
I fff58013  # addi x0, x11, -1
I 00b0a223  # sw   x11, 4(x1)
R 10000093 01 00000100
R 0000a103 02 12345678
R 001101b3 03 12345778
R 80000237 04 80000000
R 003222b3 05 00000001
R 40308333 06 edcba988
R 002343b3 07 fffffff0
R 0070a423 00 00000000
R 0080a403 08 fffffff0
R 003474b3 09 12345770
R 0054e533 0a 12345771
R 0100a583 0b fffffeef
R fff58013 00 00000000
R 00b0a223 00 00000000
S 00000108 fffffff0
S 00000104 fffffeef

//--- tb/tb_frv_pipeline.sv
// --------------------
// Testbench for the pipeline. Feeds the instruction stream from the pattern file,
// models data memory with random grants and checks every retire and store
// --------------------
`default_nettype none

module tb_frv_pipeline;

    localparam int RESET_CYCLES = 16;
    localparam int TAIL_CYCLES  = 8;                    // Idle cycles watched after last retire

    logic                    g_clk;
    logic                    arst_n;
    logic                    instr_valid;
    logic                    instr_ready;
    frv_core_pkg::instr_t    instr_data;
    logic                    dmem_req;
    logic                    dmem_wen;
    frv_core_pkg::xlen_t     dmem_addr;
    frv_core_pkg::xlen_t     dmem_wdata;
    logic                    dmem_gnt;
    frv_core_pkg::xlen_t     dmem_rdata;
    logic                    trs_valid;
    frv_core_pkg::instr_t    trs_instr;
    frv_core_pkg::reg_addr_t trs_rd;
    frv_core_pkg::xlen_t     trs_wdata;

    // Pattern file contents
    frv_core_pkg::instr_t    instr_q[$];                // Input order
    frv_core_pkg::instr_t    exp_instr_q[$];
    frv_core_pkg::reg_addr_t exp_rd_q[$];
    frv_core_pkg::xlen_t     exp_wdata_q[$];
    frv_core_pkg::xlen_t     exp_st_addr_q[$];
    frv_core_pkg::xlen_t     exp_st_data_q[$];
    frv_core_pkg::xlen_t     mem[frv_core_pkg::xlen_t]; // Data memory model

    logic [15:0]             lfsr;
    logic                    offering;                  // Word on the input port
    logic                    req_waiting;               // Request seen without grant
    logic                    held_wen;
    frv_core_pkg::xlen_t     held_addr;
    frv_core_pkg::xlen_t     held_wdata;
    int                      acc_idx;                   // Next word to offer
    int                      ret_idx;
    int                      st_idx;
    int                      mismatch_count;
    int                      other_count;
    int                      cycles;
    int                      cycle_limit;
    int                      tail;

    frv_pipeline #(
        .NUM_REGS   (32)
    ) dut0 (
        .g_clk, .arst_n,
        .instr_valid, .instr_ready, .instr_data,
        .dmem_req, .dmem_wen, .dmem_addr, .dmem_wdata, .dmem_gnt, .dmem_rdata,
        .trs_valid, .trs_instr, .trs_rd, .trs_wdata
    );

    always #2 g_clk = ~g_clk;                           // Period 4

    // Feedback polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic random_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    function automatic frv_core_pkg::xlen_t mem_read(input frv_core_pkg::xlen_t addr);
        return mem.exists(addr) ? mem[addr] : ~addr;    // Unwritten reads inverted address
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // --------------------
    // Pattern file
    task automatic load_patterns();
        int                      fd;
        int                      n;
        int                      bad_lines;             // Fields missing or unreadable
        logic [7:0]              kind;
        string                   rest;
        frv_core_pkg::xlen_t     a;
        frv_core_pkg::xlen_t     b;
        frv_core_pkg::reg_addr_t r;
        bad_lines = 0;
        fd = $fopen("tb/frv_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tb/frv_patterns.txt");
            other_count++;
            return;
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": n = $fgets(rest, fd);              // Comment to end of line
                "M": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n == 2) begin
                        mem[a] = b;
                    end else begin
                        bad_lines++;
                    end
                end
                "I": begin
                    n = $fscanf(fd, "%h", a);
                    if (n == 1) begin
                        instr_q.push_back(a);
                    end else begin
                        bad_lines++;
                    end
                end
                "R": begin
                    n = $fscanf(fd, "%h %h %h", a, r, b);
                    if (n == 3) begin
                        exp_instr_q.push_back(a);
                        exp_rd_q.push_back(r);
                        exp_wdata_q.push_back(b);
                    end else begin
                        bad_lines++;
                    end
                end
                "S": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n == 2) begin
                        exp_st_addr_q.push_back(a);
                        exp_st_data_q.push_back(b);
                    end else begin
                        bad_lines++;
                    end
                end
                default: begin
                    $display("Unknown line kind %c in the pattern file", kind);
                    other_count++;
                    n = $fgets(rest, fd);
                end
            endcase
        end
        $fclose(fd);
        if (bad_lines != 0) begin
            $display("Pattern file has %0d lines with missing or unreadable fields",
                     bad_lines);
            other_count++;
        end
        if (instr_q.size() != exp_instr_q.size()) begin
            $display("Pattern file has %0d instructions but %0d retire records",
                     instr_q.size(), exp_instr_q.size());
            other_count++;
        end
    endtask

    // --------------------
    // Per-cycle driving 1 unit after the rising edge
    task automatic drive_inputs();
        if (!offering && acc_idx < instr_q.size()) begin
            offering = random_bit();                    // Random gap before next word
        end
        instr_valid = offering;
        instr_data  = offering ? instr_q[acc_idx] : '0;
        dmem_gnt    = random_bit();
        dmem_rdata  = (dmem_req && !dmem_wen) ? mem_read(dmem_addr) : '0;
    endtask

    // Sampled at the falling edge when everything has settled
    task automatic sample_outputs();
        string tag;
        if (instr_valid && instr_ready) begin
            acc_idx++;
            offering = 1'b0;
        end
        if (req_waiting) begin                          // Ungranted request must not move
            compare_value("dmem_req held", 32'd1, dmem_req);
            compare_value("dmem_wen held", held_wen, dmem_wen);
            compare_value("dmem_addr held", held_addr, dmem_addr);
            compare_value("dmem_wdata held", held_wdata, dmem_wdata);
        end
        req_waiting = dmem_req && !dmem_gnt;
        held_wen    = dmem_wen;
        held_addr   = dmem_addr;
        held_wdata  = dmem_wdata;
        if (dmem_req && dmem_gnt && dmem_wen) begin
            if (st_idx < exp_st_addr_q.size()) begin
                tag = $sformatf("store %0d", st_idx);
                compare_value({tag, " address"}, exp_st_addr_q[st_idx], dmem_addr);
                compare_value({tag, " data"}, exp_st_data_q[st_idx], dmem_wdata);
                st_idx++;
            end else begin
                $display("A store was granted after all expected stores were seen");
                other_count++;
            end
            mem[dmem_addr] = dmem_wdata;
        end
        if (trs_valid) begin
            if (ret_idx < exp_instr_q.size()) begin
                tag = $sformatf("retire %0d", ret_idx);
                compare_value({tag, " trs_instr"}, exp_instr_q[ret_idx], trs_instr);
                compare_value({tag, " trs_rd"}, exp_rd_q[ret_idx], trs_rd);
                compare_value({tag, " trs_wdata"}, exp_wdata_q[ret_idx], trs_wdata);
                ret_idx++;
            end else begin
                $display("An instruction retired after all expected retires were seen");
                other_count++;
            end
        end
    endtask

    // --------------------
    // Main sequence
    initial begin
        g_clk          = 1'b0;
        arst_n         = 1'b0;
        instr_valid    = 1'b0;
        instr_data     = '0;
        dmem_gnt       = 1'b0;
        dmem_rdata     = '0;
        lfsr           = 16'd41;                        // Seed
        offering       = 1'b0;
        req_waiting    = 1'b0;
        acc_idx        = 0;
        ret_idx        = 0;
        st_idx         = 0;
        mismatch_count = 0;
        other_count    = 0;
        tail           = 0;
        load_patterns();
        cycle_limit = 40 * instr_q.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge g_clk);
        #1 arst_n = 1'b1;
        cycles = RESET_CYCLES;
        while (tail < TAIL_CYCLES && cycles < cycle_limit) begin
            @(posedge g_clk);
            #1;
            drive_inputs();
            @(negedge g_clk);
            sample_outputs();
            cycles++;
            if (ret_idx >= exp_instr_q.size()) begin
                tail++;
            end
        end
        if (tail < TAIL_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, ret_idx, exp_instr_q.size());
            other_count++;
        end
        if (st_idx < exp_st_addr_q.size()) begin
            $display("Only %0d of %0d expected stores were granted", st_idx,
                     exp_st_addr_q.size());
            other_count++;
        end
        $display("Errors: %0d value mismatches, %0d other failures", mismatch_count,
                 other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
